// File: rw_types_pkg.sv
`default_nettype none

package rw_types_pkg;

    // ----------------------------------------
    // Field widths
    // ----------------------------------------

    // Byte address into graph memory
    localparam int ADDR_WIDTH = 32;

    // One vertex data word
    localparam int DATA_WIDTH = 32;

    // Vertex index, doubles as the memory tag
    localparam int INDEX_WIDTH = 16;

    // Destination field of a memory response
    localparam int MODULE_ID_WIDTH = 1;

    // One bit wider than an index so a full index range fits
    localparam int COUNT_WIDTH = INDEX_WIDTH + 1;

    // Word index to byte address
    localparam int WORD_SHIFT = 2;

    // ----------------------------------------
    // Vector types
    // ----------------------------------------

    // Memory byte address
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // Vertex data word
    typedef logic [DATA_WIDTH-1:0] data_t;

    // Vertex index and memory tag
    typedef logic [INDEX_WIDTH-1:0] index_t;

    // Response destination
    typedef logic [MODULE_ID_WIDTH-1:0] module_id_t;

    // Packet and outstanding-read counters
    typedef logic [COUNT_WIDTH-1:0] count_t;

endpackage : rw_types_pkg

`default_nettype wire

// File: rw_config_pkg.sv
`default_nettype none

package rw_config_pkg;

    // ----------------------------------------
    // Response routing
    // ----------------------------------------

    // Configuration block and generator
    localparam int NUM_MODULES = 2;

    localparam rw_types_pkg::module_id_t MODULE_CONFIG    = 1'b0;
    localparam rw_types_pkg::module_id_t MODULE_GENERATOR = 1'b1;

    // ----------------------------------------
    // Configuration words
    // ----------------------------------------

    // Tag of a configuration response selects the word
    localparam rw_types_pkg::index_t CFG_SEL_BASE  = 16'd0;
    localparam rw_types_pkg::index_t CFG_SEL_COUNT = 16'd1;
    localparam rw_types_pkg::index_t CFG_SEL_MODE  = 16'd2;

    // Bit 0 of the mode word
    typedef enum logic [0:0] {
        MODE_READ  = 1'b0,
        MODE_WRITE = 1'b1
    } mode_t;

    // Configuration collector
    typedef enum logic [0:0] {
        CFG_COLLECT,
        CFG_READY
    } cfg_state_t;

    // Generator control
    typedef enum logic [1:0] {
        GEN_IDLE,
        GEN_RUN,
        GEN_DONE
    } gen_state_t;

endpackage : rw_config_pkg

`default_nettype wire

// File: rw_response_router.sv
`timescale 1ns/100ps
`default_nettype none

module rw_response_router (
    input  logic                     ap_clk,
    input  logic                     areset,
    input  logic                     response_valid,
    input  rw_types_pkg::module_id_t response_module,
    input  rw_types_pkg::index_t     response_tag,
    input  rw_types_pkg::data_t      response_data,
    output logic                     cfg_valid,
    output rw_types_pkg::index_t     cfg_tag,
    output rw_types_pkg::data_t      cfg_data,
    output logic                     gen_response_valid,
    output rw_types_pkg::index_t     gen_response_tag,
    output rw_types_pkg::data_t      gen_response_data
);

    import rw_types_pkg::*;
    import rw_config_pkg::*;

    // One-hot destination of the current response
    logic [NUM_MODULES-1:0] dest_hit;

    // Decode the module field once
    always_comb begin
        for (int i = 0; i < NUM_MODULES; i++) begin
            dest_hit[i] = response_valid && (response_module == module_id_t'(i));
        end
    end

    // Strobes towards each destination
    always_ff @(posedge ap_clk) begin
        if (areset) begin
            cfg_valid          <= 1'b0;
            gen_response_valid <= 1'b0;
        end else begin
            cfg_valid          <= dest_hit[MODULE_CONFIG];
            gen_response_valid <= dest_hit[MODULE_GENERATOR];
        end
    end

    // Payload is copied to both sides, only the strobe differs
    always_ff @(posedge ap_clk) begin
        cfg_tag           <= response_tag;
        cfg_data          <= response_data;
        gen_response_tag  <= response_tag;
        gen_response_data <= response_data;
    end

endmodule : rw_response_router

`default_nettype wire

// File: rw_configure_memory.sv
`timescale 1ns/100ps
`default_nettype none

module rw_configure_memory (
    input  logic                 ap_clk,
    input  logic                 areset,
    input  logic                 cfg_valid,
    input  rw_types_pkg::index_t cfg_tag,
    input  rw_types_pkg::data_t  cfg_data,
    output logic                 config_ready,
    output rw_types_pkg::addr_t  config_base,
    output rw_types_pkg::count_t config_count,
    output rw_config_pkg::mode_t config_mode
);

    import rw_types_pkg::*;
    import rw_config_pkg::*;

    cfg_state_t state;

    // One flag per configuration word
    logic seen_base;
    logic seen_count;
    logic seen_mode;

    // Word selected this cycle
    logic hit_base;
    logic hit_count;
    logic hit_mode;

    logic collecting;
    logic all_seen;

    always_comb begin
        collecting = (state == CFG_COLLECT);
        hit_base   = collecting && cfg_valid && (cfg_tag == CFG_SEL_BASE);
        hit_count  = collecting && cfg_valid && (cfg_tag == CFG_SEL_COUNT);
        hit_mode   = collecting && cfg_valid && (cfg_tag == CFG_SEL_MODE);
        // Includes the word arriving now
        all_seen   = (seen_base || hit_base) && (seen_count || hit_count)
                     && (seen_mode || hit_mode);
    end

    // ----------------------------------------
    // Collector FSM
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset) begin
            state      <= CFG_COLLECT;
            seen_base  <= 1'b0;
            seen_count <= 1'b0;
            seen_mode  <= 1'b0;
        end else begin
            seen_base  <= seen_base || hit_base;
            seen_count <= seen_count || hit_count;
            seen_mode  <= seen_mode || hit_mode;
            case (state)
                CFG_COLLECT: begin
                    if (all_seen) begin
                        state <= CFG_READY;
                    end
                end
                // Ready until reset
                CFG_READY: state <= CFG_READY;
                default:   state <= CFG_COLLECT;
            endcase
        end
    end

    // Record only changes while collecting
    always_ff @(posedge ap_clk) begin
        if (hit_base) begin
            config_base <= cfg_data;
        end
        if (hit_count) begin
            config_count <= cfg_data[COUNT_WIDTH-1:0];
        end
        if (hit_mode) begin
            config_mode <= mode_t'(cfg_data[0]);
        end
    end

    assign config_ready = (state == CFG_READY);

endmodule : rw_configure_memory

`default_nettype wire

// File: rw_generator.sv
`timescale 1ns/100ps
`default_nettype none

module rw_generator (
    input  logic                 ap_clk,
    input  logic                 areset,
    input  logic                 start,
    input  logic                 config_ready,
    input  rw_types_pkg::addr_t  config_base,
    input  rw_types_pkg::count_t config_count,
    input  rw_config_pkg::mode_t config_mode,
    input  logic                 packet_valid,
    input  rw_types_pkg::index_t packet_index,
    input  rw_types_pkg::data_t  packet_data,
    input  logic                 gen_response_valid,
    input  rw_types_pkg::index_t gen_response_tag,
    input  rw_types_pkg::data_t  gen_response_data,
    output logic                 request_memory_valid,
    output logic                 request_memory_write,
    output rw_types_pkg::addr_t  request_memory_address,
    output rw_types_pkg::index_t request_memory_tag,
    output rw_types_pkg::data_t  request_memory_data,
    output logic                 request_engine_valid,
    output rw_types_pkg::index_t request_engine_index,
    output rw_types_pkg::data_t  request_engine_data,
    output logic                 done
);

    import rw_types_pkg::*;
    import rw_config_pkg::*;

    gen_state_t state;

    // Descriptor seen before configuration was ready
    logic start_seen;

    count_t accepted_count;
    count_t accepted_next;
    count_t outstanding_count;
    count_t outstanding_next;

    logic  accept;
    logic  read_issue;
    logic  write_mode;
    addr_t packet_address;

    // ----------------------------------------
    // Accept and count
    // ----------------------------------------
    always_comb begin
        write_mode     = (config_mode == MODE_WRITE);
        // Packets outside GEN_RUN or past the count are dropped
        accept         = packet_valid && (state == GEN_RUN)
                         && (accepted_count != config_count);
        read_issue     = accept && !write_mode;
        packet_address = config_base + (addr_t'(packet_index) << WORD_SHIFT);
        accepted_next  = accepted_count + count_t'(accept);
        // Read and response in one cycle cancel
        case ({read_issue, gen_response_valid})
            2'b10:   outstanding_next = outstanding_count + count_t'(1);
            2'b01:   outstanding_next = outstanding_count - count_t'(1);
            default: outstanding_next = outstanding_count;
        endcase
    end

    // ----------------------------------------
    // Control FSM
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset) begin
            state             <= GEN_IDLE;
            start_seen        <= 1'b0;
            accepted_count    <= '0;
            outstanding_count <= '0;
        end else begin
            accepted_count    <= accepted_next;
            outstanding_count <= outstanding_next;
            if (start) begin
                start_seen <= 1'b1;
            end
            case (state)
                GEN_IDLE: begin
                    // Start strobe and configuration, in either order
                    if ((start || start_seen) && config_ready) begin
                        state <= GEN_RUN;
                    end
                end
                GEN_RUN: begin
                    // Look ahead so done does not lag a cycle
                    if ((accepted_next == config_count) && (outstanding_next == '0)) begin
                        state <= GEN_DONE;
                    end
                end
                GEN_DONE: state <= GEN_DONE;
                default:  state <= GEN_IDLE;
            endcase
        end
    end

    // Request and response strobes
    always_ff @(posedge ap_clk) begin
        if (areset) begin
            request_memory_valid <= 1'b0;
            request_engine_valid <= 1'b0;
        end else begin
            request_memory_valid <= accept;
            request_engine_valid <= gen_response_valid;
        end
    end

    // Request fields, zero data on reads
    always_ff @(posedge ap_clk) begin
        request_memory_write   <= write_mode;
        request_memory_address <= packet_address;
        request_memory_tag     <= packet_index;
        request_memory_data    <= write_mode ? packet_data : '0;
        // Read data returns as an engine packet
        request_engine_index   <= gen_response_tag;
        request_engine_data    <= gen_response_data;
    end

    assign done = (state == GEN_DONE);

endmodule : rw_generator

`default_nettype wire

// File: engine_read_write.sv
`timescale 1ns/100ps
`default_nettype none

module engine_read_write (
    input  logic                     ap_clk,
    input  logic                     areset_read_write_engine,
    input  logic                     descriptor_valid,
    input  logic                     response_engine_valid,
    input  rw_types_pkg::index_t     response_engine_index,
    input  rw_types_pkg::data_t      response_engine_data,
    input  logic                     response_memory_valid,
    input  rw_types_pkg::module_id_t response_memory_module,
    input  rw_types_pkg::index_t     response_memory_tag,
    input  rw_types_pkg::data_t      response_memory_data,
    output logic                     request_memory_valid,
    output logic                     request_memory_write,
    output rw_types_pkg::addr_t      request_memory_address,
    output rw_types_pkg::index_t     request_memory_tag,
    output rw_types_pkg::data_t      request_memory_data,
    output logic                     request_engine_valid,
    output rw_types_pkg::index_t     request_engine_index,
    output rw_types_pkg::data_t      request_engine_data,
    output logic                     done_out
);

    import rw_types_pkg::*;
    import rw_config_pkg::*;

    // Local reset copies
    logic areset_io;
    logic areset_router;
    logic areset_configure_memory;
    logic areset_generator;

    // Registered inputs
    logic       descriptor_valid_reg;
    logic       response_engine_valid_reg;
    index_t     response_engine_index_reg;
    data_t      response_engine_data_reg;
    logic       response_memory_valid_reg;
    module_id_t response_memory_module_reg;
    index_t     response_memory_tag_reg;
    data_t      response_memory_data_reg;

    // Router to configuration block
    logic   cfg_valid;
    index_t cfg_tag;
    data_t  cfg_data;

    // Router to generator
    logic   gen_response_valid;
    index_t gen_response_tag;
    data_t  gen_response_data;

    // Configuration record
    logic   config_ready;
    addr_t  config_base;
    count_t config_count;
    mode_t  config_mode;

    // Generator outputs ahead of the output register
    logic   gen_request_memory_valid;
    logic   gen_request_memory_write;
    addr_t  gen_request_memory_address;
    index_t gen_request_memory_tag;
    data_t  gen_request_memory_data;
    logic   gen_request_engine_valid;
    index_t gen_request_engine_index;
    data_t  gen_request_engine_data;
    logic   gen_done;

    // ----------------------------------------
    // Reset fan-out
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        areset_io               <= areset_read_write_engine;
        areset_router           <= areset_read_write_engine;
        areset_configure_memory <= areset_read_write_engine;
        areset_generator        <= areset_read_write_engine;
    end

    // ----------------------------------------
    // Input and output registers
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_io) begin
            descriptor_valid_reg      <= 1'b0;
            response_engine_valid_reg <= 1'b0;
            response_memory_valid_reg <= 1'b0;
            request_memory_valid      <= 1'b0;
            request_engine_valid      <= 1'b0;
            done_out                  <= 1'b0;
        end else begin
            descriptor_valid_reg      <= descriptor_valid;
            response_engine_valid_reg <= response_engine_valid;
            response_memory_valid_reg <= response_memory_valid;
            request_memory_valid      <= gen_request_memory_valid;
            request_engine_valid      <= gen_request_engine_valid;
            done_out                  <= gen_done;
        end
    end

    // Payload side, no reset
    always_ff @(posedge ap_clk) begin
        response_engine_index_reg  <= response_engine_index;
        response_engine_data_reg   <= response_engine_data;
        response_memory_module_reg <= response_memory_module;
        response_memory_tag_reg    <= response_memory_tag;
        response_memory_data_reg   <= response_memory_data;
        request_memory_write       <= gen_request_memory_write;
        request_memory_address     <= gen_request_memory_address;
        request_memory_tag         <= gen_request_memory_tag;
        request_memory_data        <= gen_request_memory_data;
        request_engine_index       <= gen_request_engine_index;
        request_engine_data        <= gen_request_engine_data;
    end

    // Memory responses split by module field
    rw_response_router i_response_router (
        .ap_clk             (ap_clk),
        .areset             (areset_router),
        .response_valid     (response_memory_valid_reg),
        .response_module    (response_memory_module_reg),
        .response_tag       (response_memory_tag_reg),
        .response_data      (response_memory_data_reg),
        .cfg_valid          (cfg_valid),
        .cfg_tag            (cfg_tag),
        .cfg_data           (cfg_data),
        .gen_response_valid (gen_response_valid),
        .gen_response_tag   (gen_response_tag),
        .gen_response_data  (gen_response_data)
    );

    rw_configure_memory i_configure_memory (
        .ap_clk       (ap_clk),
        .areset       (areset_configure_memory),
        .cfg_valid    (cfg_valid),
        .cfg_tag      (cfg_tag),
        .cfg_data     (cfg_data),
        .config_ready (config_ready),
        .config_base  (config_base),
        .config_count (config_count),
        .config_mode  (config_mode)
    );

    rw_generator i_generator (
        .ap_clk                 (ap_clk),
        .areset                 (areset_generator),
        .start                  (descriptor_valid_reg),
        .config_ready           (config_ready),
        .config_base            (config_base),
        .config_count           (config_count),
        .config_mode            (config_mode),
        .packet_valid           (response_engine_valid_reg),
        .packet_index           (response_engine_index_reg),
        .packet_data            (response_engine_data_reg),
        .gen_response_valid     (gen_response_valid),
        .gen_response_tag       (gen_response_tag),
        .gen_response_data      (gen_response_data),
        .request_memory_valid   (gen_request_memory_valid),
        .request_memory_write   (gen_request_memory_write),
        .request_memory_address (gen_request_memory_address),
        .request_memory_tag     (gen_request_memory_tag),
        .request_memory_data    (gen_request_memory_data),
        .request_engine_valid   (gen_request_engine_valid),
        .request_engine_index   (gen_request_engine_index),
        .request_engine_data    (gen_request_engine_data),
        .done                   (gen_done)
    );

endmodule : engine_read_write

`default_nettype wire

// File: tb_engine_read_write_props.sv
`timescale 1ns/100ps
`default_nettype none

module tb_engine_read_write_props (
    input logic                ap_clk,
    input logic                areset_read_write_engine,
    input logic                request_memory_valid,
    input logic                request_memory_write,
    input rw_types_pkg::addr_t request_memory_address,
    input logic                request_engine_valid,
    input logic                done_out
);

    import rw_types_pkg::*;

    // Set by the first write of a run
    logic write_run;

    always_ff @(posedge ap_clk) begin
        if (areset_read_write_engine) begin
            write_run <= 1'b0;
        end else if (request_memory_valid && request_memory_write) begin
            write_run <= 1'b1;
        end
    end

    // ----------------------------------------
    // Port protocol
    // ----------------------------------------

    // Two cycles of reset reach the outputs
    assert property (@(posedge ap_clk)
        areset_read_write_engine && $past(areset_read_write_engine)
        && $past(areset_read_write_engine, 2)
        |-> !request_memory_valid && !request_engine_valid && !done_out)
    else $error("valid output or done_out high during reset");

    // Done is sticky
    assert property (@(posedge ap_clk) disable iff (areset_read_write_engine)
        done_out |=> done_out)
    else $error("done_out fell without reset");

    // Word-aligned addresses only
    assert property (@(posedge ap_clk) disable iff (areset_read_write_engine)
        request_memory_valid |-> (request_memory_address[WORD_SHIFT-1:0] == '0))
    else $error("memory request address not word aligned");

    // No read data in a write run
    assert property (@(posedge ap_clk) disable iff (areset_read_write_engine)
        write_run |-> !request_engine_valid)
    else $error("engine packet during a write-mode run");

endmodule : tb_engine_read_write_props

bind engine_read_write tb_engine_read_write_props i_props (.*);

`default_nettype wire

// File: tb_engine_read_write.sv
`timescale 1ns/100ps
`default_nettype none

module tb_engine_read_write;

    import rw_types_pkg::*;
    import rw_config_pkg::*;

    localparam int TIMEOUT_CYCLES = 64;

    logic       ap_clk;
    logic       areset_read_write_engine;
    logic       descriptor_valid;
    logic       response_engine_valid;
    index_t     response_engine_index;
    data_t      response_engine_data;
    logic       response_memory_valid;
    module_id_t response_memory_module;
    index_t     response_memory_tag;
    data_t      response_memory_data;
    logic       request_memory_valid;
    logic       request_memory_write;
    addr_t      request_memory_address;
    index_t     request_memory_tag;
    data_t      request_memory_data;
    logic       request_engine_valid;
    index_t     request_engine_index;
    data_t      request_engine_data;
    logic       done_out;

    // xorshift state
    logic [31:0] rnd_state;

    // Expected memory requests, oldest first
    logic   exp_write[$];
    addr_t  exp_address[$];
    index_t exp_tag[$];
    data_t  exp_data[$];
    int     exp_due[$];

    // Expected engine packets from read responses
    index_t eng_index[$];
    data_t  eng_data[$];
    int     eng_due[$];

    // Reads seen on the bus, still to be answered
    index_t answer_tags[$];

    int cycle = 0;

    // Accepted reads whose engine packet has not come back yet
    int pending_reads;

    engine_read_write i_dut (.*);

    always #2 ap_clk = ~ap_clk;

    always @(posedge ap_clk) begin
        cycle <= cycle + 1;
    end

    function automatic logic [31:0] xorshift_next();
        logic [31:0] x;
        x = rnd_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rnd_state = x;
        return x;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got === exp) else begin
            fail_run($sformatf("mismatch at %0t ns: %s got 0x%08h expected 0x%08h",
                               $time, name, got, exp));
        end
    endtask

    // No done while a read is still outstanding
    assert property (@(posedge ap_clk) disable iff (areset_read_write_engine)
                     (pending_reads != 0) |-> !done_out)
    else begin
        fail_run($sformatf("done_out high at %0t ns with %0d reads outstanding",
                           $time, pending_reads));
    end

    // ----------------------------------------
    // Output checker, sampled mid-cycle
    // ----------------------------------------
    always @(negedge ap_clk) begin
        if (!areset_read_write_engine) begin
            if (request_memory_valid) begin
                if (exp_tag.size() == 0) begin
                    fail_run($sformatf("unexpected memory request at %0t ns", $time));
                end
                compare_value("request_memory_valid cycle", 32'(cycle), 32'(exp_due.pop_front()));
                compare_value("request_memory_write", 32'(request_memory_write),
                              32'(exp_write.pop_front()));
                compare_value("request_memory_address", request_memory_address,
                              exp_address.pop_front());
                compare_value("request_memory_tag", 32'(request_memory_tag),
                              32'(exp_tag.pop_front()));
                compare_value("request_memory_data", request_memory_data,
                              exp_data.pop_front());
                if (!request_memory_write) begin
                    answer_tags.push_back(request_memory_tag);
                end
            end
            if (request_engine_valid) begin
                if (eng_index.size() == 0) begin
                    fail_run($sformatf("unexpected engine packet at %0t ns", $time));
                end
                compare_value("request_engine_valid cycle", 32'(cycle), 32'(eng_due.pop_front()));
                compare_value("request_engine_index", 32'(request_engine_index),
                              32'(eng_index.pop_front()));
                compare_value("request_engine_data", request_engine_data,
                              eng_data.pop_front());
                // Read has made the full round trip
                pending_reads--;
            end
        end
    end

    task automatic idle(input int n);
        repeat (n) @(negedge ap_clk);
    endtask

    task automatic apply_reset();
        areset_read_write_engine = 1'b1;
        repeat (16) @(negedge ap_clk);
        areset_read_write_engine = 1'b0;
        // Reset fan-out adds a cycle inside the DUT
        idle(4);
    endtask

    task automatic drive_config_word(input index_t sel, input data_t value);
        response_memory_valid  = 1'b1;
        response_memory_module = MODULE_CONFIG;
        response_memory_tag    = sel;
        response_memory_data   = value;
        @(negedge ap_clk);
        response_memory_valid = 1'b0;
    endtask

    // Three words in a shuffled order
    task automatic send_config(input addr_t base, input int count, input logic write);
        index_t order[3];
        index_t tmp;
        int     j;
        data_t  mode_word;
        order[0] = CFG_SEL_BASE;
        order[1] = CFG_SEL_COUNT;
        order[2] = CFG_SEL_MODE;
        for (int i = 2; i > 0; i--) begin
            j = int'(xorshift_next() % 32'(i + 1));
            tmp = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int i = 0; i < 3; i++) begin
            if (order[i] == CFG_SEL_BASE) begin
                drive_config_word(order[i], base);
            end else if (order[i] == CFG_SEL_COUNT) begin
                drive_config_word(order[i], 32'(count));
            end else begin
                // Random upper bits, only bit 0 selects the mode
                mode_word    = xorshift_next();
                mode_word[0] = write;
                drive_config_word(order[i], mode_word);
            end
        end
    endtask

    task automatic send_start();
        descriptor_valid = 1'b1;
        @(negedge ap_clk);
        descriptor_valid = 1'b0;
    endtask

    // First n_accept packets are expected as requests, the rest dropped
    task automatic send_packets(input int n_total, input int n_accept, input addr_t base,
                                input logic write);
        logic [31:0] r;
        for (int i = 0; i < n_total; i++) begin
            r = xorshift_next();
            response_engine_valid = 1'b1;
            response_engine_index = r[15:0];
            response_engine_data  = xorshift_next();
            if (i < n_accept) begin
                exp_write.push_back(write);
                exp_address.push_back(base + (addr_t'(r[15:0]) << 2));
                exp_tag.push_back(r[15:0]);
                exp_data.push_back(write ? response_engine_data : '0);
                exp_due.push_back(cycle + 3);
                if (!write) begin
                    pending_reads++;
                end
            end
            @(negedge ap_clk);
            response_engine_valid = 1'b0;
            if (r[31]) begin
                @(negedge ap_clk);
            end
        end
    endtask

    task automatic answer_reads(input int n);
        int t;
        repeat (n) begin
            t = 0;
            while (answer_tags.size() == 0) begin
                if (t >= TIMEOUT_CYCLES) begin
                    fail_run("timeout waiting for a read request to answer");
                end
                @(negedge ap_clk);
                t++;
            end
            response_memory_valid  = 1'b1;
            response_memory_module = MODULE_GENERATOR;
            response_memory_tag    = answer_tags.pop_front();
            response_memory_data   = xorshift_next();
            eng_index.push_back(response_memory_tag);
            eng_data.push_back(response_memory_data);
            eng_due.push_back(cycle + 4);
            @(negedge ap_clk);
            response_memory_valid = 1'b0;
        end
    endtask

    task automatic wait_drained();
        int t;
        t = 0;
        while (exp_tag.size() != 0 || eng_index.size() != 0) begin
            if (t >= TIMEOUT_CYCLES) begin
                fail_run("timeout waiting for expected outputs");
            end
            @(negedge ap_clk);
            t++;
        end
    endtask

    task automatic wait_done();
        int t;
        t = 0;
        while (!done_out) begin
            if (t >= 20) begin
                fail_run("timeout waiting for done_out");
            end
            @(negedge ap_clk);
            t++;
        end
        // Props check that it holds
        idle(8);
    endtask

    initial begin
        addr_t base;
        ap_clk                   = 1'b0;
        areset_read_write_engine = 1'b1;
        descriptor_valid         = 1'b0;
        response_engine_valid    = 1'b0;
        response_engine_index    = '0;
        response_engine_data     = '0;
        response_memory_valid    = 1'b0;
        response_memory_module   = '0;
        response_memory_tag      = '0;
        response_memory_data     = '0;
        rnd_state                = 32'd89;
        pending_reads            = 0;
        apply_reset();

        // ----------------------------------------
        // Idle engine drops early packets
        // ----------------------------------------
        compare_value("done_out", 32'(done_out), 32'd0);
        send_packets(4, 0, '0, 1'b0);
        idle(10);

        // Write mode, start after configuration
        base = xorshift_next() & 32'hFFFF_FFF0;
        send_config(base, 6, 1'b1);
        send_start();
        idle(6);
        send_packets(9, 6, base, 1'b1);
        // Late mode word in the write run, stays with the configuration block
        drive_config_word(CFG_SEL_MODE, 32'd0);
        wait_drained();
        wait_done();

        // Read mode, start before configuration
        apply_reset();
        send_start();
        idle(2);
        base = xorshift_next() & 32'hFFFF_FFF0;
        send_config(base, 5, 1'b0);
        idle(6);
        send_packets(7, 5, base, 1'b0);
        answer_reads(5);
        wait_drained();
        wait_done();

        $display("TEST PASS");
        $finish;
    end

endmodule : tb_engine_read_write

`default_nettype wire

// File: files.f
rw_types_pkg.sv
rw_config_pkg.sv
rw_response_router.sv
rw_configure_memory.sv
rw_generator.sv
engine_read_write.sv
tb_engine_read_write_props.sv
tb_engine_read_write.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f files.f --top-module tb_engine_read_write
	./obj_dir/Vtb_engine_read_write | tee /dev/stderr | grep -q "TEST PASS"

clean:
	rm -rf obj_dir
